/* src.f */
+incdir+src
src/rename_types_pkg.sv
src/rename_ctrl_pkg.sv
src/rename_map_table.sv
src/rename_free_list.sv
src/rename_stage.sv
src/rename_top.sv
bench/rename_checker.sv
bench/rename_tb.sv

/* Makefile */
SIM = obj_dir/rename_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	verilator --binary --assert --timing -f src.f --top-module rename_tb -o rename_sim
	./$(SIM) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* bench/rename_tb.sv */
`include "rename_cfg.svh"

module rename_tb
    import rename_types_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FW = `FETCH_WIDTH;
    localparam int FD = `FREE_DEPTH;
    localparam int ROB = `ROB_DEPTH;
    localparam int ROB_W = $clog2(`ROB_DEPTH);
    localparam int NUM_RANDOM = 150;
    localparam int TOTAL_GROUPS = 170;
    localparam int CYCLE_LIMIT = 5 + FD + 4 * TOTAL_GROUPS;

    logic clk;
    logic reset;
    slot_mask_t in_valid, in_rd_we, commit_valid;
    areg_t [FW-1:0] in_rs1, in_rs2, in_rd, commit_rd;
    logic stall, redirect, rob_tail_dir;
    logic [ROB_W-1:0] rob_tail_idx;
    preg_t [FW-1:0] commit_prd, commit_old_prd;
    slot_mask_t out_valid, out_rd_we, out_rob_dir;
    preg_t [FW-1:0] out_prs1, out_prs2, out_prd, out_old_prd;
    logic [FW-1:0][ROB_W-1:0] out_rob_idx;
    slot_count_t valid_count;
    logic no_free;

    // Reference model state
    preg_t model_spec [`AREG_COUNT];
    preg_t model_arch [`AREG_COUNT];
    preg_t fl_mem [FD];
    int spec_head, commit_head, fl_tail, rob_ptr;
    areg_t if_rd [$];
    preg_t if_prd [$];
    preg_t if_old [$];

    slot_mask_t exp_valid, exp_rd_we, exp_rob_dir;
    preg_t [FW-1:0] exp_prs1, exp_prs2, exp_prd, exp_old;
    int exp_rob_idx [FW];
    bit exp_pending;
    int stall_pct;
    int error_count;
    int cycle_count;

    rename_top rename_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            error_count++;
            $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic bit model_no_free();
        return (fl_tail - spec_head) < FW;
    endfunction

    // Renames slot by slot, so earlier writers are seen by later slots
    function automatic void predict_group(input slot_mask_t v, input slot_mask_t we,
                                          input areg_t [FW-1:0] s1, input areg_t [FW-1:0] s2,
                                          input areg_t [FW-1:0] d);
        int idx;
        int dir;
        for (int i = 0; i < FW; i++) begin
            exp_prs1[i] = model_spec[s1[i]];
            exp_prs2[i] = model_spec[s2[i]];
            exp_prd[i] = '0;
            exp_old[i] = '0;
            idx = rob_ptr % ROB + i;
            dir = rob_ptr / ROB;
            if (idx >= ROB) begin
                idx = idx - ROB;
                dir = dir ^ 1; // Wrap flips direction
            end
            exp_rob_idx[i] = idx;
            exp_rob_dir[i] = dir[0];
            if (v[i] && we[i]) begin
                exp_old[i] = model_spec[d[i]];
                exp_prd[i] = fl_mem[spec_head % FD];
                spec_head++;
                model_spec[d[i]] = exp_prd[i];
                if_rd.push_back(d[i]);
                if_prd.push_back(exp_prd[i]);
                if_old.push_back(exp_old[i]);
            end
        end
        exp_valid = v;
        exp_rd_we = v & we;
        rob_ptr = (rob_ptr + $countones(v)) % (2 * ROB);
    endfunction

    function automatic void apply_commits(input slot_mask_t cv, input areg_t [FW-1:0] crd,
                                          input preg_t [FW-1:0] cprd,
                                          input preg_t [FW-1:0] cold);
        for (int i = 0; i < FW; i++) begin
            if (cv[i]) begin
                model_arch[crd[i]] = cprd[i];
                fl_mem[fl_tail % FD] = cold[i]; // Old mapping goes back to the tail
                fl_tail++;
                commit_head++;
            end
        end
    endfunction

    // Holds the group until it fires, or for one cycle with redirect
    task automatic present_group(input slot_mask_t v, input slot_mask_t we,
                                 input areg_t [FW-1:0] s1, input areg_t [FW-1:0] s2,
                                 input areg_t [FW-1:0] d, input bit commits_on,
                                 input bit redir);
        bit fired;
        bit stall_now;
        int n;
        slot_mask_t cv;
        areg_t [FW-1:0] crd;
        preg_t [FW-1:0] cprd;
        preg_t [FW-1:0] cold;
        fired = 1'b0;
        while (!fired) begin
            @(posedge clk);
            stall_now = !redir && (($urandom % 100) < stall_pct);
            cv = '0;
            crd = '0;
            cprd = '0;
            cold = '0;
            n = commits_on ? int'($urandom % (FW + 1)) : 0;
            if (n > if_rd.size()) begin
                n = if_rd.size();
            end
            for (int i = 0; i < n; i++) begin
                cv[i] = 1'b1;
                crd[i] = if_rd.pop_front();
                cprd[i] = if_prd.pop_front();
                cold[i] = if_old.pop_front();
            end
            in_valid <= v;
            in_rd_we <= we;
            in_rs1 <= s1;
            in_rs2 <= s2;
            in_rd <= d;
            stall <= stall_now;
            redirect <= redir;
            rob_tail_idx <= ROB_W'(rob_ptr % ROB);
            rob_tail_dir <= rob_ptr >= ROB;
            commit_valid <= cv;
            commit_rd <= crd;
            commit_prd <= cprd;
            commit_old_prd <= cold;
            @(negedge clk);
            check_value("no_free", int'(no_free), int'(model_no_free()));
            check_value("valid_count", int'(valid_count), $countones(v));
            fired = !stall_now && !model_no_free() && !redir;
            if (fired) begin
                predict_group(v, we, s1, s2, d);
                exp_pending = 1'b1;
            end
            apply_commits(cv, crd, cprd, cold);
            if (redir) begin
                model_spec = model_arch;
                spec_head = commit_head; // Uncommitted allocations rewind
                if_rd.delete();
                if_prd.delete();
                if_old.delete();
                fired = 1'b1;
            end
        end
    endtask

    task automatic random_group(input bit wide, input bit commits_on, input bit redir);
        slot_mask_t v;
        slot_mask_t we;
        areg_t [FW-1:0] s1;
        areg_t [FW-1:0] s2;
        areg_t [FW-1:0] d;
        int range;
        range = wide ? `AREG_COUNT : 8; // Narrow range makes dependencies likely
        v = slot_mask_t'($urandom);
        we = slot_mask_t'($urandom);
        for (int i = 0; i < FW; i++) begin
            s1[i] = areg_t'($urandom % range);
            s2[i] = areg_t'($urandom % range);
            d[i] = areg_t'($urandom % range);
        end
        present_group(v, we, s1, s2, d, commits_on, redir);
    endtask

    // Compares the registered group one cycle after it fired
    initial begin
        slot_mask_t c_valid, c_we, c_dir;
        preg_t [FW-1:0] c_prs1, c_prs2, c_prd, c_old;
        int c_rob [FW];
        forever begin
            @(posedge clk);
            if (exp_pending) begin
                exp_pending = 1'b0;
                c_valid = exp_valid;
                c_we = exp_rd_we;
                c_dir = exp_rob_dir;
                c_prs1 = exp_prs1;
                c_prs2 = exp_prs2;
                c_prd = exp_prd;
                c_old = exp_old;
                c_rob = exp_rob_idx;
                @(negedge clk);
                check_value("out_valid", int'(out_valid), int'(c_valid));
                check_value("out_rd_we", int'(out_rd_we), int'(c_we));
                for (int i = 0; i < FW; i++) begin
                    if (c_valid[i]) begin
                        check_value($sformatf("out_prs1[%0d]", i),
                                    int'(out_prs1[i]), int'(c_prs1[i]));
                        check_value($sformatf("out_prs2[%0d]", i),
                                    int'(out_prs2[i]), int'(c_prs2[i]));
                        check_value($sformatf("out_rob_idx[%0d]", i),
                                    int'(out_rob_idx[i]), c_rob[i]);
                        check_value($sformatf("out_rob_dir[%0d]", i),
                                    int'(out_rob_dir[i]), int'(c_dir[i]));
                    end
                    if (c_we[i]) begin
                        check_value($sformatf("out_prd[%0d]", i),
                                    int'(out_prd[i]), int'(c_prd[i]));
                        check_value($sformatf("out_old_prd[%0d]", i),
                                    int'(out_old_prd[i]), int'(c_old[i]));
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h8d358473));
        reset = 1'b1;
        in_valid = '0;
        in_rd_we = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_rd = '0;
        stall = 1'b0;
        redirect = 1'b0;
        rob_tail_idx = '0;
        rob_tail_dir = 1'b0;
        commit_valid = '0;
        commit_rd = '0;
        commit_prd = '0;
        commit_old_prd = '0;
        exp_pending = 1'b0;
        error_count = 0;
        cycle_count = 0;
        stall_pct = 20;
        for (int i = 0; i < `AREG_COUNT; i++) begin
            model_spec[i] = preg_t'(i);
            model_arch[i] = preg_t'(i);
        end
        for (int i = 0; i < FD; i++) begin
            fl_mem[i] = preg_t'(`AREG_COUNT + i);
        end
        spec_head = 0;
        commit_head = 0;
        fl_tail = FD;
        rob_ptr = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (no_free) begin
            @(negedge clk); // Free list filling
        end

        // Reads only, prs equals areg
        present_group(4'b1111, 4'b0000, {5'd7, 5'd31, 5'd0, 5'd12},
                      {5'd1, 5'd2, 5'd19, 5'd25}, '0, 1'b0, 1'b0);
        // Drain the queue without commits
        for (int g = 0; g < FD / FW; g++) begin
            random_group(1'b1, 1'b0, 1'b0);
            if (g == 0) begin
                stall_pct = 0;
            end
        end
        stall_pct = 20;
        // Full writer groups until empty, then wait for commits
        while (!model_no_free()) begin
            present_group(4'b1111, 4'b1111, '0, '0, {5'd9, 5'd8, 5'd7, 5'd6}, 1'b0, 1'b0);
        end
        present_group(4'b1111, 4'b1111, '0, '0, {5'd4, 5'd3, 5'd2, 5'd1}, 1'b1, 1'b0);
        // Same rd written three times, then read back
        present_group(4'b1111, 4'b0111, {5'd1, 5'd3, 5'd3, 5'd3},
                      {5'd2, 5'd3, 5'd1, 5'd3}, {5'd0, 5'd3, 5'd3, 5'd3}, 1'b1, 1'b0);
        present_group(4'b0001, 4'b0000, {5'd0, 5'd0, 5'd0, 5'd3}, '0, '0, 1'b1, 1'b0);

        for (int g = 0; g < NUM_RANDOM; g++) begin
            random_group(g % 3 == 0, 1'b1, g % 40 == 39);
        end
        present_group('0, '0, '0, '0, '0, 1'b0, 1'b0);
        present_group('0, '0, '0, '0, '0, 1'b0, 1'b0);
        repeat (2) @(negedge clk); // Last group compared by now
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/rename_checker.sv */
`include "rename_cfg.svh"

module rename_checker
    import rename_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic                      no_free,
    input  slot_mask_t                out_valid,
    input  slot_mask_t                out_rd_we,
    input  preg_t [`FETCH_WIDTH-1:0]  out_prd,
    input  preg_t [`FETCH_WIDTH-1:0]  out_prs1,
    input  preg_t [`FETCH_WIDTH-1:0]  out_prs2
);
    timeunit 1ns;
    timeprecision 1ps;

    int since_reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            since_reset <= 0;
        end else if (since_reset < `FREE_DEPTH + 1) begin
            since_reset <= since_reset + 1;
        end
    end

    redirect_clears: assert property (@(posedge clk) disable iff (reset)
        redirect |=> out_valid == '0)
        else $error("out_valid not cleared after redirect");

    stall_holds: assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect) |=> ($stable(out_valid) && $stable(out_prd)
            && $stable(out_prs1) && $stable(out_prs2)))
        else $error("outputs changed during stall");

    fill_blocks: assert property (@(posedge clk) disable iff (reset)
        since_reset < `FREE_DEPTH |-> no_free)
        else $error("no_free low while the free list fills");

    // Every pair of writing slots must own different registers
    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_outer
        for (genvar j = i + 1; j < `FETCH_WIDTH; j++) begin : g_inner
            prd_distinct: assert property (@(posedge clk) disable iff (reset)
                (out_valid[i] && out_rd_we[i] && out_valid[j] && out_rd_we[j])
                    |-> out_prd[i] != out_prd[j])
                else $error("duplicate out_prd in slots %0d and %0d", i, j);
        end
    end

endmodule

bind rename_top rename_checker rename_checker_inst (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .no_free   (no_free),
    .out_valid (out_valid),
    .out_rd_we (out_rd_we),
    .out_prd   (out_prd),
    .out_prs1  (out_prs1),
    .out_prs2  (out_prs2)
);

/* src/rename_top.sv */
`include "rename_cfg.svh"

module rename_top
    import rename_types_pkg::*;
    import rename_ctrl_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,

    input  slot_mask_t                    in_valid,
    input  slot_mask_t                    in_rd_we,
    input  areg_t [`FETCH_WIDTH-1:0]      in_rs1,
    input  areg_t [`FETCH_WIDTH-1:0]      in_rs2,
    input  areg_t [`FETCH_WIDTH-1:0]      in_rd,
    input  logic                          stall,
    input  logic                          redirect,
    input  rob_idx_t                      rob_tail_idx,
    input  logic                          rob_tail_dir,

    input  slot_mask_t                    commit_valid,
    input  areg_t [`FETCH_WIDTH-1:0]      commit_rd,
    input  preg_t [`FETCH_WIDTH-1:0]      commit_prd,
    input  preg_t [`FETCH_WIDTH-1:0]      commit_old_prd,

    output slot_mask_t                    out_valid,
    output slot_mask_t                    out_rd_we,
    output preg_t [`FETCH_WIDTH-1:0]      out_prs1,
    output preg_t [`FETCH_WIDTH-1:0]      out_prs2,
    output preg_t [`FETCH_WIDTH-1:0]      out_prd,
    output preg_t [`FETCH_WIDTH-1:0]      out_old_prd,
    output rob_idx_t [`FETCH_WIDTH-1:0]   out_rob_idx,
    output slot_mask_t                    out_rob_dir,
    output slot_count_t                   valid_count,
    output logic                          no_free
);

    areg_t [`FETCH_WIDTH-1:0] rd_addr1;
    areg_t [`FETCH_WIDTH-1:0] rd_addr2;
    areg_t [`FETCH_WIDTH-1:0] rd_addr_d;
    slot_mask_t               spec_we;
    areg_t [`FETCH_WIDTH-1:0] spec_areg;
    preg_t [`FETCH_WIDTH-1:0] spec_preg;
    preg_t [`FETCH_WIDTH-1:0] prs1_map;
    preg_t [`FETCH_WIDTH-1:0] prs2_map;
    preg_t [`FETCH_WIDTH-1:0] old_prd_map;
    preg_t [`FETCH_WIDTH-1:0] alloc_prd;
    slot_count_t              alloc_count;

    rename_stage rename_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .redirect     (redirect),
        .no_free      (no_free),
        .in_valid     (in_valid),
        .in_rd_we     (in_rd_we),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_rd        (in_rd),
        .rob_tail_idx (rob_tail_idx),
        .rob_tail_dir (rob_tail_dir),
        .prs1_map     (prs1_map),
        .prs2_map     (prs2_map),
        .old_prd_map  (old_prd_map),
        .alloc_prd    (alloc_prd),
        .rd_addr1     (rd_addr1),
        .rd_addr2     (rd_addr2),
        .rd_addr_d    (rd_addr_d),
        .spec_we      (spec_we),
        .spec_areg    (spec_areg),
        .spec_preg    (spec_preg),
        .alloc_count  (alloc_count),
        .valid_count  (valid_count),
        .out_valid    (out_valid),
        .out_rd_we    (out_rd_we),
        .out_prs1     (out_prs1),
        .out_prs2     (out_prs2),
        .out_prd      (out_prd),
        .out_old_prd  (out_old_prd),
        .out_rob_idx  (out_rob_idx),
        .out_rob_dir  (out_rob_dir)
    );

    rename_map_table rename_map_table_inst (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .rd_addr1     (rd_addr1),
        .rd_addr2     (rd_addr2),
        .rd_addr_d    (rd_addr_d),
        .spec_we      (spec_we),
        .spec_areg    (spec_areg),
        .spec_preg    (spec_preg),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_prd   (commit_prd),
        .prs1_map     (prs1_map),
        .prs2_map     (prs2_map),
        .old_prd_map  (old_prd_map)
    );

    // Each commit frees the register its rd held before
    rename_free_list rename_free_list_inst (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .alloc_count  (alloc_count),
        .free_valid   (commit_valid),
        .free_preg    (commit_old_prd),
        .alloc_prd    (alloc_prd),
        .no_free      (no_free)
    );

endmodule

/* src/rename_stage.sv */
`include "rename_cfg.svh"

module rename_stage
    import rename_types_pkg::*;
    import rename_ctrl_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          redirect,
    input  logic                          no_free,

    input  slot_mask_t                    in_valid,
    input  slot_mask_t                    in_rd_we,
    input  areg_t [`FETCH_WIDTH-1:0]      in_rs1,
    input  areg_t [`FETCH_WIDTH-1:0]      in_rs2,
    input  areg_t [`FETCH_WIDTH-1:0]      in_rd,

    input  rob_idx_t                      rob_tail_idx,
    input  logic                          rob_tail_dir,

    input  preg_t [`FETCH_WIDTH-1:0]      prs1_map,
    input  preg_t [`FETCH_WIDTH-1:0]      prs2_map,
    input  preg_t [`FETCH_WIDTH-1:0]      old_prd_map,
    input  preg_t [`FETCH_WIDTH-1:0]      alloc_prd,

    output areg_t [`FETCH_WIDTH-1:0]      rd_addr1,
    output areg_t [`FETCH_WIDTH-1:0]      rd_addr2,
    output areg_t [`FETCH_WIDTH-1:0]      rd_addr_d,
    output slot_mask_t                    spec_we,
    output areg_t [`FETCH_WIDTH-1:0]      spec_areg,
    output preg_t [`FETCH_WIDTH-1:0]      spec_preg,
    output slot_count_t                   alloc_count,
    output slot_count_t                   valid_count,

    output slot_mask_t                    out_valid,
    output slot_mask_t                    out_rd_we,
    output preg_t [`FETCH_WIDTH-1:0]      out_prs1,
    output preg_t [`FETCH_WIDTH-1:0]      out_prs2,
    output preg_t [`FETCH_WIDTH-1:0]      out_prd,
    output preg_t [`FETCH_WIDTH-1:0]      out_old_prd,
    output rob_idx_t [`FETCH_WIDTH-1:0]   out_rob_idx,
    output slot_mask_t                    out_rob_dir
);

    localparam int ROB_W = $bits(rob_idx_t);

    typedef logic [ROB_W:0] rob_sum_t;

    logic                       fire;
    slot_mask_t                 wr;
    slot_mask_t                 last_wr;
    slot_count_t                wr_total;
    preg_t [`FETCH_WIDTH-1:0]   new_prd;
    preg_t [`FETCH_WIDTH-1:0]   prs1;
    preg_t [`FETCH_WIDTH-1:0]   prs2;
    preg_t [`FETCH_WIDTH-1:0]   old_prd;
    rob_idx_t [`FETCH_WIDTH-1:0] rob_idx;
    slot_mask_t                 rob_dir;

    assign fire = ~stall & ~no_free & ~redirect;
    assign wr   = in_valid & in_rd_we;

    assign rd_addr1  = in_rs1;
    assign rd_addr2  = in_rs2;
    assign rd_addr_d = in_rd;
    assign spec_areg = in_rd;
    assign spec_preg = new_prd;
    assign spec_we   = fire ? last_wr : '0;

    assign alloc_count = fire ? wr_total : '0;

    always_comb begin
        valid_count = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            valid_count = valid_count + slot_count_t'(in_valid[i]);
        end
    end

    // Writer k takes the k-th queue head
    always_comb begin
        slot_count_t pos;
        pos = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            new_prd[i] = wr[i] ? alloc_prd[pos] : '0;
            pos = pos + slot_count_t'(wr[i]);
        end
        wr_total = pos;
    end

    // Later j overrides, so the nearest earlier writer wins
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            prs1[i]    = prs1_map[i];
            prs2[i]    = prs2_map[i];
            old_prd[i] = old_prd_map[i];
            last_wr[i] = wr[i];
            for (int j = 0; j < i; j++) begin
                if (wr[j] && in_rd[j] == in_rs1[i]) begin
                    prs1[i] = new_prd[j];
                end
                if (wr[j] && in_rd[j] == in_rs2[i]) begin
                    prs2[i] = new_prd[j];
                end
                if (wr[j] && in_rd[j] == in_rd[i]) begin
                    old_prd[i] = new_prd[j];
                end
            end
            for (int j = i + 1; j < `FETCH_WIDTH; j++) begin
                if (wr[j] && in_rd[j] == in_rd[i]) begin
                    last_wr[i] = 1'b0; // Overwritten later in the group
                end
            end
        end
    end

    always_comb begin
        rob_sum_t sum;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            sum = {1'b0, rob_tail_idx} + rob_sum_t'(i);
            if (sum >= rob_sum_t'(`ROB_DEPTH)) begin
                rob_idx[i] = rob_idx_t'(sum - rob_sum_t'(`ROB_DEPTH));
                rob_dir[i] = ~rob_tail_dir; // Wrapped past the end
            end else begin
                rob_idx[i] = rob_idx_t'(sum);
                rob_dir[i] = rob_tail_dir;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            out_valid <= '0;
            out_rd_we <= '0;
        end else if (fire) begin
            out_valid <= in_valid;
            out_rd_we <= wr;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_prs1    <= prs1;
            out_prs2    <= prs2;
            out_prd     <= new_prd;
            out_old_prd <= old_prd;
            out_rob_idx <= rob_idx;
            out_rob_dir <= rob_dir;
        end
    end

endmodule

/* src/rename_free_list.sv */
`include "rename_cfg.svh"

module rename_free_list
    import rename_types_pkg::*;
    import rename_ctrl_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          redirect,

    input  slot_count_t                   alloc_count,

    input  slot_mask_t                    free_valid,
    input  preg_t [`FETCH_WIDTH-1:0]      free_preg,

    output preg_t [`FETCH_WIDTH-1:0]      alloc_prd,
    output logic                          no_free
);

    localparam int IDX_W = $clog2(`FREE_DEPTH);

    preg_t       queue [`FREE_DEPTH];
    fl_state_t   state;
    fl_ptr_t     spec_head;
    fl_ptr_t     commit_head;
    fl_ptr_t     tail;
    fl_ptr_t     free_count;
    slot_count_t push_count;

    always_comb begin
        push_count = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            push_count = push_count + slot_count_t'(free_valid[i]);
        end
    end

    assign free_count = tail - spec_head;
    assign no_free = (state == FL_FILL) || (free_count < fl_ptr_t'(`FETCH_WIDTH));

    // Next FETCH_WIDTH heads, visible before the pop
    always_comb begin
        fl_ptr_t rd_ptr;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            rd_ptr = spec_head + fl_ptr_t'(i);
            alloc_prd[i] = queue[rd_ptr[IDX_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        fl_ptr_t wr_ptr;
        if (state == FL_FILL) begin
            queue[tail[IDX_W-1:0]] <= preg_t'(`AREG_COUNT) + preg_t'(tail[IDX_W-1:0]);
        end else begin
            wr_ptr = tail;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (free_valid[i]) begin
                    queue[wr_ptr[IDX_W-1:0]] <= free_preg[i];
                    wr_ptr = wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= FL_FILL;
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= '0;
        end else begin
            case (state)
                FL_FILL: begin
                    tail <= tail + 1'b1;
                    if (tail[IDX_W-1:0] == IDX_W'(`FREE_DEPTH - 1)) begin
                        state <= FL_RUN; // Tail wraps, queue full
                    end
                end
                FL_RUN: begin
                    tail        <= tail + fl_ptr_t'(push_count);
                    commit_head <= commit_head + fl_ptr_t'(push_count);
                    if (redirect) begin
                        spec_head <= commit_head + fl_ptr_t'(push_count);
                    end else begin
                        spec_head <= spec_head + fl_ptr_t'(alloc_count);
                    end
                end
                default: state <= FL_FILL;
            endcase
        end
    end

endmodule

/* src/rename_map_table.sv */
`include "rename_cfg.svh"

module rename_map_table
    import rename_types_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          redirect,

    input  areg_t [`FETCH_WIDTH-1:0]      rd_addr1,
    input  areg_t [`FETCH_WIDTH-1:0]      rd_addr2,
    input  areg_t [`FETCH_WIDTH-1:0]      rd_addr_d,

    input  slot_mask_t                    spec_we,
    input  areg_t [`FETCH_WIDTH-1:0]      spec_areg,
    input  preg_t [`FETCH_WIDTH-1:0]      spec_preg,

    input  slot_mask_t                    commit_valid,
    input  areg_t [`FETCH_WIDTH-1:0]      commit_rd,
    input  preg_t [`FETCH_WIDTH-1:0]      commit_prd,

    output preg_t [`FETCH_WIDTH-1:0]      prs1_map,
    output preg_t [`FETCH_WIDTH-1:0]      prs2_map,
    output preg_t [`FETCH_WIDTH-1:0]      old_prd_map
);

    preg_t spec_map [`AREG_COUNT];
    preg_t arch_map [`AREG_COUNT];
    preg_t arch_next [`AREG_COUNT]; // Architectural view after this cycle's commits

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            prs1_map[i]    = spec_map[rd_addr1[i]];
            prs2_map[i]    = spec_map[rd_addr2[i]];
            old_prd_map[i] = spec_map[rd_addr_d[i]];
        end
    end

    // Commits arrive in program order, so a later slot wins
    always_comb begin
        arch_next = arch_map;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (commit_valid[i]) begin
                arch_next[commit_rd[i]] = commit_prd[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `AREG_COUNT; i++) begin
                arch_map[i] <= preg_t'(i); // Identity mapping
            end
        end else begin
            arch_map <= arch_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `AREG_COUNT; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (redirect) begin
            spec_map <= arch_next; // One-cycle recovery
        end else begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (spec_we[i]) begin
                    spec_map[spec_areg[i]] <= spec_preg[i];
                end
            end
        end
    end

endmodule

/* src/rename_ctrl_pkg.sv */
`include "rename_cfg.svh"

package rename_ctrl_pkg;

    typedef enum logic {
        FL_FILL, // Loading initial free registers
        FL_RUN
    } fl_state_t;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // Queue index plus wrap bit
    typedef logic [$clog2(`FREE_DEPTH):0] fl_ptr_t;

endpackage

/* src/rename_types_pkg.sv */
`include "rename_cfg.svh"

package rename_types_pkg;

    // Architectural register number
    typedef logic [$clog2(`AREG_COUNT)-1:0] areg_t;

    // Physical register number
    typedef logic [$clog2(`PREG_COUNT)-1:0] preg_t;

    typedef logic [`FETCH_WIDTH-1:0] slot_mask_t; // One bit per slot

    // Holds 0 up to FETCH_WIDTH inclusive
    typedef logic [$clog2(`FETCH_WIDTH+1)-1:0] slot_count_t;

endpackage

/* src/rename_cfg.svh */
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Slots renamed per cycle
`define FETCH_WIDTH 4

`define AREG_COUNT 32 // Architectural registers
`define PREG_COUNT 64 // Physical registers

// Reorder buffer entries, index wraps with a direction bit
`define ROB_DEPTH 32

// Registers not held by the architectural state
`define FREE_DEPTH (`PREG_COUNT - `AREG_COUNT)

`endif
